// ==== Bender.yml ====
package:
  name: galaksija_keyboard

sources:
  - include_dirs:
      - source
    files:
      - source/ps2Pkg.sv
      - source/keyMatrixPkg.sv
      - source/scanLink.sv
      - source/ps2Receiver.sv
      - source/scanFifo.sv
      - source/keyMatrix.sv
      - source/galaksijaKeyboard.sv
  - target: test
    files:
      - testbench/tbGalaksijaKeyboard.sv

// ==== project.f ====
+incdir+source
source/ps2Pkg.sv
source/keyMatrixPkg.sv
source/scanLink.sv
source/ps2Receiver.sv
source/scanFifo.sv
source/keyMatrix.sv
source/galaksijaKeyboard.sv
testbench/tbGalaksijaKeyboard.sv

// ==== source/galaksijaKeyboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module galaksijaKeyboard (
	input logic clk,
	input logic reset,
	input logic ps2Clk,
	input logic ps2Data,
	input logic [5:0] addr,
	input logic rdKey,
	output logic [7:0] keyOut,
	output logic overrun
);

	scanLink rxLink ();  // receiver to FIFO
	scanLink matrixLink ();  // FIFO to matrix

	ps2Receiver ps2Receiver_i (
		.clk(clk),
		.reset(reset),
		.ps2Clk(ps2Clk),
		.ps2Data(ps2Data),
		.link(rxLink),
		.overrun(overrun)
	);

	scanFifo scanFifo_i (
		.clk(clk),
		.reset(reset),
		.inLink(rxLink),
		.outLink(matrixLink)
	);

	keyMatrix keyMatrix_i (
		.clk(clk),
		.reset(reset),
		.link(matrixLink),
		.addr(addr),
		.rdKey(rdKey),
		.keyOut(keyOut)
	);

endmodule

`default_nettype wire

// ==== source/keyMatrix.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "keyboard_defs.svh"

module keyMatrix (
	input logic clk,
	input logic reset,
	scanLink.consumer link,
	input keyMatrixPkg::keyIndex addr,
	input logic rdKey,
	output logic [7:0] keyOut
);

	keyMatrixPkg::keyBitmap held;
	keyMatrixPkg::keyMap hit;
	logic [`KBD_KEY_COUNT-1:0] keyMask;
	logic ack;

	function automatic keyMatrixPkg::keyMap translate(input ps2Pkg::keyEvent ev);
		keyMatrixPkg::keyMap m;
		m = keyMatrixPkg::KEY_NONE;
		m.mapped = 1'b1;
		if (ev.extended) begin
			m.index = keyMatrixPkg::KEY_ENTER;  // keypad enter only
			m.mapped = (ev.code == 8'h5A);
		end else begin
			case (ev.code)
				8'h1C: m.index = 6'd1;  // A
				8'h32: m.index = 6'd2;
				8'h21: m.index = 6'd3;
				8'h23: m.index = 6'd4;
				8'h24: m.index = 6'd5;
				8'h2B: m.index = 6'd6;
				8'h34: m.index = 6'd7;
				8'h33: m.index = 6'd8;
				8'h43: m.index = 6'd9;
				8'h3B: m.index = 6'd10;
				8'h42: m.index = 6'd11;
				8'h4B: m.index = 6'd12;
				8'h3A: m.index = 6'd13;
				8'h31: m.index = 6'd14;
				8'h44: m.index = 6'd15;
				8'h4D: m.index = 6'd16;
				8'h15: m.index = 6'd17;
				8'h2D: m.index = 6'd18;
				8'h1B: m.index = 6'd19;
				8'h2C: m.index = 6'd20;
				8'h3C: m.index = 6'd21;
				8'h2A: m.index = 6'd22;
				8'h1D: m.index = 6'd23;
				8'h22: m.index = 6'd24;
				8'h35: m.index = 6'd25;
				8'h1A: m.index = 6'd26;  // Z
				8'h66: m.index = 6'd29;  // backspace
				8'h29: m.index = 6'd31;  // space
				8'h45, 8'h70: m.index = 6'd32;  // 0, main row and keypad
				8'h16, 8'h69: m.index = 6'd33;
				8'h1E, 8'h72: m.index = 6'd34;
				8'h26, 8'h7A: m.index = 6'd35;
				8'h25, 8'h6B: m.index = 6'd36;
				8'h2E, 8'h73: m.index = 6'd37;
				8'h36, 8'h74: m.index = 6'd38;
				8'h3D, 8'h6C: m.index = 6'd39;
				8'h3E, 8'h75: m.index = 6'd40;
				8'h46, 8'h7D: m.index = 6'd41;  // 9
				8'h4C: m.index = 6'd42;  // ;
				8'h7C: m.index = 6'd43;  // : on keypad star
				8'h41: m.index = 6'd44;
				8'h55: m.index = 6'd45;
				8'h49: m.index = 6'd46;
				8'h4A: m.index = 6'd47;
				8'h5A: m.index = keyMatrixPkg::KEY_ENTER;
				8'h76: m.index = 6'd49;  // escape
				8'h12, 8'h59: m.index = keyMatrixPkg::KEY_SHIFT;
				8'h52: begin
					m.index = 6'd33;  // ! is shifted 1
					m.addShift = 1'b1;
				end
				default: m.mapped = 1'b0;
			endcase
		end
		return m;
	endfunction

	assign hit = translate(link.evt);

	always_comb begin
		keyMask = '0;
		keyMask[hit.index] = 1'b1;
		if (hit.addShift) keyMask[keyMatrixPkg::KEY_SHIFT] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ack <= 1'b0;
			held <= '0;
		end else if (link.req && !ack) begin
			ack <= 1'b1;  // bitmap updates in the same cycle
			if (hit.mapped) held <= link.evt.released ? (held & ~keyMask) : (held | keyMask);
		end else if (!link.req) begin
			ack <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) keyOut <= 8'hFF;
		else if (rdKey) keyOut <= held[addr] ? 8'hFE : 8'hFF;  // active low pressed
	end

	assign link.ack = ack;

	ackFollowsReq: assert property (@(posedge clk) disable iff (reset)
		link.ack |-> ($past(link.req) || $past(link.ack)));

endmodule

`default_nettype wire

// ==== source/keyMatrixPkg.sv ====
`default_nettype none

`include "keyboard_defs.svh"

package keyMatrixPkg;

	typedef logic [$clog2(`KBD_KEY_COUNT)-1:0] keyIndex;
	typedef logic [`KBD_KEY_COUNT-1:0] keyBitmap;

	// translation result of one scancode
	typedef struct packed {
		logic mapped;  // low for codes the matrix ignores
		logic addShift;  // key also holds shift
		keyIndex index;
	} keyMap;

	localparam keyIndex KEY_ENTER = 6'd48;
	localparam keyIndex KEY_SHIFT = 6'd53;

	localparam keyMap KEY_NONE = '{mapped: 1'b0, addShift: 1'b0, index: '0};

endpackage

`default_nettype wire

// ==== source/keyboard_defs.svh ====
`ifndef KEYBOARD_DEFS_SVH
`define KEYBOARD_DEFS_SVH

// scan FIFO entries, must be a power of two
`define KBD_FIFO_DEPTH 8

// system cycles without a PS/2 clock edge before a partial frame is dropped
`define KBD_PS2_TIMEOUT 2048

// keys in the Galaksija matrix
`define KBD_KEY_COUNT 64

`endif

// ==== source/ps2Pkg.sv ====
`default_nettype none

package ps2Pkg;

	typedef logic [7:0] scanCode;

	// start, eight data bits LSB first, odd parity, stop
	typedef logic [10:0] ps2Frame;

	typedef struct packed {
		scanCode code;
		logic released;  // F0 seen before the code
		logic extended;  // E0 seen before the code
	} keyEvent;

	localparam scanCode PREFIX_BREAK = 8'hF0;
	localparam scanCode PREFIX_EXTENDED = 8'hE0;

endpackage

`default_nettype wire

// ==== source/ps2Receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "keyboard_defs.svh"

module ps2Receiver (
	input logic clk,
	input logic reset,
	input logic ps2Clk,
	input logic ps2Data,
	scanLink.producer link,
	output logic overrun
);

	localparam int TIMER_WIDTH = $clog2(`KBD_PS2_TIMEOUT);

	logic [2:0] clkSync;  // two sync stages plus edge history
	logic [1:0] dataSync;
	logic fallEdge;
	ps2Pkg::ps2Frame shiftReg;
	ps2Pkg::ps2Frame frame;
	ps2Pkg::scanCode code;
	logic [3:0] bitCount;
	logic [TIMER_WIDTH-1:0] idleTimer;
	logic frameDone;
	logic frameGood;
	logic timeout;
	logic isPrefix;
	logic offer;
	logic releasedFlag;
	logic extendedFlag;
	logic req;
	ps2Pkg::keyEvent evt;

	always_ff @(posedge clk) begin
		if (reset) begin
			clkSync <= '1;  // lines idle high
			dataSync <= '1;
		end else begin
			clkSync <= {clkSync[1:0], ps2Clk};
			dataSync <= {dataSync[0], ps2Data};
		end
	end

	assign fallEdge = clkSync[2] & ~clkSync[1];
	assign frame = {dataSync[1], shiftReg[10:1]};  // new bit enters at the top
	assign code = frame[8:1];
	assign frameDone = fallEdge && (bitCount == 4'd10);
	assign frameGood = !frame[0] && frame[10] && (^frame[9:1]);
	assign timeout = !fallEdge && (bitCount != 4'd0)
		&& (idleTimer == TIMER_WIDTH'(`KBD_PS2_TIMEOUT - 1));
	assign isPrefix = (code == ps2Pkg::PREFIX_BREAK) || (code == ps2Pkg::PREFIX_EXTENDED);
	assign offer = frameDone && frameGood && !isPrefix && !req && !link.ack;

	always_ff @(posedge clk) begin
		if (fallEdge) shiftReg <= frame;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			bitCount <= 4'd0;
			idleTimer <= '0;
		end else if (fallEdge) begin
			bitCount <= frameDone ? 4'd0 : bitCount + 4'd1;
			idleTimer <= '0;
		end else if (timeout) begin
			bitCount <= 4'd0;  // abandon partial frame
			idleTimer <= '0;
		end else if (bitCount != 4'd0) begin
			idleTimer <= idleTimer + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			req <= 1'b0;
			overrun <= 1'b0;
			releasedFlag <= 1'b0;
			extendedFlag <= 1'b0;
		end else begin
			overrun <= 1'b0;
			if (req && link.ack) req <= 1'b0;
			if (timeout || (frameDone && !frameGood)) begin
				releasedFlag <= 1'b0;
				extendedFlag <= 1'b0;
			end else if (frameDone && code == ps2Pkg::PREFIX_BREAK) begin
				releasedFlag <= 1'b1;
			end else if (frameDone && code == ps2Pkg::PREFIX_EXTENDED) begin
				extendedFlag <= 1'b1;
			end else if (frameDone) begin
				releasedFlag <= 1'b0;
				extendedFlag <= 1'b0;
				if (offer) req <= 1'b1;
				else overrun <= 1'b1;  // previous handshake still open
			end
		end
	end

	always_ff @(posedge clk) begin
		if (offer) evt <= '{code: code, released: releasedFlag, extended: extendedFlag};
	end

	assign link.req = req;
	assign link.evt = evt;
	assign link.busy = (bitCount != 4'd0);

	reqRiseAckLow: assert property (@(posedge clk) disable iff (reset)
		$rose(link.req) |-> !link.ack);

	evtStable: assert property (@(posedge clk) disable iff (reset)
		link.req ##1 link.req |-> $stable(link.evt));

endmodule

`default_nettype wire

// ==== source/scanFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "keyboard_defs.svh"

module scanFifo (
	input logic clk,
	input logic reset,
	scanLink.consumer inLink,
	scanLink.producer outLink
);

	localparam int DEPTH = `KBD_FIFO_DEPTH;
	localparam int PTR_WIDTH = $clog2(DEPTH);

	ps2Pkg::keyEvent mem [DEPTH];
	logic [PTR_WIDTH-1:0] wrPtr;
	logic [PTR_WIDTH-1:0] rdPtr;
	logic [PTR_WIDTH:0] count;
	logic inAck;
	logic outReq;
	logic full;
	logic empty;
	logic push;
	logic pop;

	assign full = (count == (PTR_WIDTH + 1)'(DEPTH));
	assign empty = (count == '0);
	assign push = inLink.req && !inAck && !full;  // full withholds ack
	assign pop = outReq && outLink.ack;

	always_ff @(posedge clk) begin
		if (push) mem[wrPtr] <= inLink.evt;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			inAck <= 1'b0;
			outReq <= 1'b0;
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) inAck <= 1'b1;
			else if (!inLink.req) inAck <= 1'b0;
			if (pop) outReq <= 1'b0;
			else if (!outReq && !outLink.ack && !empty) outReq <= 1'b1;
			if (push) wrPtr <= wrPtr + 1'b1;  // wraps, depth is a power of two
			if (pop) rdPtr <= rdPtr + 1'b1;
			count <= count + (PTR_WIDTH + 1)'(push) - (PTR_WIDTH + 1)'(pop);
		end
	end

	assign inLink.ack = inAck;
	assign outLink.req = outReq;
	assign outLink.evt = mem[rdPtr];  // head stays put until pop
	assign outLink.busy = !empty;

	noPushWhenFull: assert property (@(posedge clk) disable iff (reset)
		$rose(inLink.ack) |-> $past(count) != DEPTH);

	noPopWhenEmpty: assert property (@(posedge clk) disable iff (reset)
		$fell(outLink.req) |-> $past(count) != 0);

	// receiver offers only between frames
	offerBetweenFrames: assert property (@(posedge clk) disable iff (reset)
		$rose(inLink.req) |-> !inLink.busy);

endmodule

`default_nettype wire

// ==== source/scanLink.sv ====
`timescale 1ns/1ps
`default_nettype none

// four-phase req/ack link for one key event
interface scanLink;

	logic req;  // event offered
	ps2Pkg::keyEvent evt;  // held while req is high
	logic ack;  // event taken
	logic busy;  // producer has work in progress

	modport producer (
		output req,
		output evt,
		output busy,
		input ack
	);

	modport consumer (
		input req,
		input evt,
		input busy,
		output ack
	);

endinterface

`default_nettype wire

// ==== testbench/tbGalaksijaKeyboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbGalaksijaKeyboard;

	localparam int KEYS = $bits(keyMatrixPkg::keyBitmap);
	localparam int PS2_HALF = 20;  // system cycles per PS/2 clock phase
	localparam int BURST_HALF = 2;
	localparam int WAIT_LIMIT = 3000;

	logic clk = 1'b0;
	logic reset;
	logic ps2Clk;
	logic ps2Data;
	logic [5:0] addr;
	logic rdKey;
	logic [7:0] keyOut;
	logic overrun;

	keyMatrixPkg::keyBitmap refBitmap;  // expected held keys
	logic checkEnable;
	logic burstActive;
	logic [7:0] expectedOut;
	logic [7:0] expectedQ;
	int seed;

	// scancodes in key order, A..Z and 0..9
	logic [7:0] letterCodes [26] = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34,
		8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
		8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
	logic [7:0] mainDigits [10] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36,
		8'h3D, 8'h3E, 8'h46};
	logic [7:0] padDigits [10] = '{8'h70, 8'h69, 8'h72, 8'h7A, 8'h6B, 8'h73, 8'h74,
		8'h6C, 8'h75, 8'h7D};

	galaksijaKeyboard galaksijaKeyboard_i (
		.clk(clk),
		.reset(reset),
		.ps2Clk(ps2Clk),
		.ps2Data(ps2Data),
		.addr(addr),
		.rdKey(rdKey),
		.keyOut(keyOut),
		.overrun(overrun)
	);

	always #2 clk = ~clk;

	assign expectedOut = refBitmap[addr] ? 8'hFE : 8'hFF;  // active low pressed

	always @(posedge clk) begin
		expectedQ <= expectedOut;  // value for the read issued last cycle
	end

	task automatic stopRun();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string name, input logic [7:0] exp,
		input logic [7:0] got);
		$display("** Error %s exp %h got %h", name, exp, got);
		stopRun();
	endtask

	task automatic reportProblem(input string text);
		$display("Error: %s", text);
		stopRun();
	endtask

	readMatchesRef: assert property (@(posedge clk) disable iff (reset)
		rdKey && checkEnable |=> keyOut == expectedQ)
		else reportMismatch("keyOut", $sampled(expectedQ), $sampled(keyOut));

	overrunOnlyInBurst: assert property (@(posedge clk) disable iff (reset)
		!burstActive |-> !overrun)
		else reportProblem("overrun pulsed outside the burst test");

	keyOutIdleAfterReset: assert property (@(posedge clk)
		reset |=> keyOut == 8'hFF)
		else reportMismatch("keyOut", 8'hFF, $sampled(keyOut));

	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	function automatic keyMatrixPkg::keyBitmap bitOf(input int index);
		keyMatrixPkg::keyBitmap mask;
		mask = '0;
		mask[index] = 1'b1;
		return mask;
	endfunction

	// start, data LSB first, odd parity, stop
	task automatic sendFrame(input logic [7:0] code, input bit badParity, input bit badStop,
		input int halfCycles);
		logic [10:0] bits;
		bits = {~badStop, (~^code) ^ badParity, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2Data = bits[i];
			repeat (halfCycles) nextCycle();
			ps2Clk = 1'b0;  // receiver samples here
			repeat (halfCycles) nextCycle();
			ps2Clk = 1'b1;
		end
		ps2Data = 1'b1;
		repeat (halfCycles) nextCycle();
	endtask

	task automatic strikeKey(input logic [7:0] code, input bit extended, input bit released,
		input keyMatrixPkg::keyBitmap mask, input int halfCycles);
		if (extended) sendFrame(ps2Pkg::PREFIX_EXTENDED, 1'b0, 1'b0, halfCycles);
		if (released) sendFrame(ps2Pkg::PREFIX_BREAK, 1'b0, 1'b0, halfCycles);
		sendFrame(code, 1'b0, 1'b0, halfCycles);
		if (released) refBitmap = refBitmap & ~mask;
		else refBitmap = refBitmap | mask;
	endtask

	task automatic readKey(input int index, output logic [7:0] value);
		nextCycle();
		addr = 6'(index);
		rdKey = 1'b1;
		nextCycle();
		rdKey = 1'b0;
		value = keyOut;  // registered on the edge that saw rdKey
	endtask

	task automatic waitKey(input int index, input logic [7:0] expected);
		logic [7:0] value;
		int cycles;
		value = 8'h00;
		cycles = 0;
		while (value != expected && cycles < WAIT_LIMIT) begin
			readKey(index, value);
			cycles += 2;
		end
		if (value != expected) reportProblem("key state never reached");
	endtask

	task automatic checkAllKeys();
		logic [7:0] value;
		checkEnable = 1'b1;
		for (int i = 0; i < KEYS; i++) readKey(i, value);
		nextCycle();
		checkEnable = 1'b0;
	endtask

	task automatic exerciseKey(input logic [7:0] code, input bit extended, input int index,
		input keyMatrixPkg::keyBitmap mask);
		strikeKey(code, extended, 1'b0, mask, PS2_HALF);
		waitKey(index, 8'hFE);
		checkAllKeys();
		strikeKey(code, extended, 1'b1, mask, PS2_HALF);
		waitKey(index, 8'hFF);
		checkAllKeys();
	endtask

	initial begin
		int pick;
		seed = 59549;
		reset = 1'b1;
		ps2Clk = 1'b1;
		ps2Data = 1'b1;
		addr = 6'd0;
		rdKey = 1'b0;
		refBitmap = '0;
		checkEnable = 1'b0;
		burstActive = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;

		checkAllKeys();  // everything released

		for (int n = 0; n < 4; n++) begin
			pick = $unsigned($random(seed)) % 26;
			exerciseKey(letterCodes[pick], 1'b0, pick + 1, bitOf(pick + 1));
			pick = $unsigned($random(seed)) % 10;
			exerciseKey(mainDigits[pick], 1'b0, 32 + pick, bitOf(32 + pick));
			pick = $unsigned($random(seed)) % 10;
			exerciseKey(padDigits[pick], 1'b0, 32 + pick, bitOf(32 + pick));
		end

		exerciseKey(8'h12, 1'b0, 53, bitOf(53));  // left shift
		exerciseKey(8'h59, 1'b0, 53, bitOf(53));
		exerciseKey(8'h52, 1'b0, 33, bitOf(33) | bitOf(53));  // ! holds 1 and shift
		exerciseKey(8'h5A, 1'b1, 48, bitOf(48));  // keypad enter
		strikeKey(8'h75, 1'b1, 1'b0, '0, PS2_HALF);  // arrow up, not in the matrix
		exerciseKey(8'h29, 1'b0, 31, bitOf(31));

		sendFrame(letterCodes[0], 1'b1, 1'b0, PS2_HALF);
		sendFrame(letterCodes[1], 1'b0, 1'b1, PS2_HALF);
		sendFrame(ps2Pkg::PREFIX_BREAK, 1'b0, 1'b0, PS2_HALF);
		sendFrame(8'h66, 1'b1, 1'b0, PS2_HALF);  // bad frame also drops the break flag
		strikeKey(letterCodes[2], 1'b0, 1'b0, bitOf(3), PS2_HALF);
		waitKey(3, 8'hFE);
		checkAllKeys();
		strikeKey(letterCodes[2], 1'b0, 1'b1, bitOf(3), PS2_HALF);
		waitKey(3, 8'hFF);

		// fast frames back to back, final state depends on event order
		burstActive = 1'b1;
		strikeKey(letterCodes[0], 1'b0, 1'b0, bitOf(1), BURST_HALF);
		strikeKey(letterCodes[1], 1'b0, 1'b0, bitOf(2), BURST_HALF);
		strikeKey(letterCodes[0], 1'b0, 1'b1, bitOf(1), BURST_HALF);
		strikeKey(letterCodes[2], 1'b0, 1'b0, bitOf(3), BURST_HALF);
		strikeKey(letterCodes[1], 1'b0, 1'b1, bitOf(2), BURST_HALF);
		strikeKey(letterCodes[3], 1'b0, 1'b0, bitOf(4), BURST_HALF);
		strikeKey(letterCodes[3], 1'b0, 1'b1, bitOf(4), BURST_HALF);
		strikeKey(letterCodes[4], 1'b0, 1'b0, bitOf(5), BURST_HALF);
		waitKey(5, 8'hFE);
		checkAllKeys();
		burstActive = 1'b0;

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire
